// File: uart_tx_periph.f
+incdir+sim
design/uart_tx_pkg.sv
design/ahb_tx_regs.sv
design/tx_word_fifo.sv
design/uart_word_serializer.sv
design/uart_tx_periph.sv
sim/tb_uart_tx_periph.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_uart_tx_periph -Mdir obj_dir \
    -f uart_tx_periph.f \
    && ./obj_dir/Vtb_uart_tx_periph > sim.log 2>&1 \
    || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "** PASS **" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/tb_uart_checks.svh
`ifndef TB_UART_CHECKS_SVH
`define TB_UART_CHECKS_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// one step per bit taken
task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        w = {w[30:0], lfsr_state[0]};
    end
endtask

// called on the first negedge that sees the start bit, samples mid-bit
task automatic capture_frame(output logic [7:0] data, output logic start_b,
                             output logic check_b, output logic stop_b);
    data = '0;
    repeat (BIT_PERIOD / 2) @(negedge clk);
    start_b = tx;
    for (int i = 0; i < 8; i++) begin
        repeat (BIT_PERIOD) @(negedge clk);
        data = {tx, data[7:1]};  // lsb arrives first
    end
    repeat (BIT_PERIOD) @(negedge clk);
    check_b = tx;
    repeat (BIT_PERIOD) @(negedge clk);
    stop_b = tx;
endtask

task automatic check_rsp(input string name, input ahb_rsp_t got, input ahb_rsp_t exp);
    n_checks++;
    if (got !== exp) begin
        err_cnt++;
        if (got.rdata !== exp.rdata)
            $display("mismatch %s.rdata: got 0x%h expected 0x%h", name, got.rdata, exp.rdata);
        if (got.ready !== exp.ready)
            $display("mismatch %s.ready: got 0x%h expected 0x%h", name, got.ready, exp.ready);
        if (got.resp !== exp.resp)
            $display("mismatch %s.resp: got 0x%h expected 0x%h", name, got.resp, exp.resp);
    end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
        err_cnt++;
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

task automatic check_irq(input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
        err_cnt++;
        $display("mismatch irq_uart: got 0x%h expected 0x%h", got, exp);
    end
endtask

`endif

// File: sim/tb_uart_tx_periph.sv
`timescale 1ns/1ps

module tb_uart_tx_periph;

    import uart_tx_pkg::*;

    localparam int BIT_PERIOD = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_HALF   = 2;  // 4 ns period
    localparam int FRAME_CLKS = 11 * BIT_PERIOD;
    localparam int QUIET_CLKS = FRAME_CLKS + 2 * BIT_PERIOD;  // long enough for a whole frame
    localparam int WATCHDOG   = 20000;
    localparam logic [31:0] OTHER_ADDR = 32'h4000_0014;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_NOSEL, OP_IDLE, OP_CLEAR, OP_BURST, OP_RANDOM
    } op_e;

    typedef struct packed {
        op_e         kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  count;   // words in a burst or random run
        logic [3:0]  accept;  // burst writes that should get OKAY
        logic        exp_ready;
        hresp_e      exp_resp;
        logic        exp_irq;
    } test_t;

    logic     clk;
    logic     rst_n;
    ahb_req_t ahb_req;
    ahb_rsp_t ahb_rsp;
    logic     irq_clear;
    logic     tx;
    logic     irq_uart;

    test_t       tests[$];
    ahb_req_t    req_q[$];
    ahb_rsp_t    rsp_q[$];
    logic [31:0] exp_q[$];
    logic [7:0]  rx_q[$];
    logic [31:0] lfsr_state;
    int          err_cnt;
    int          n_checks;

    `include "tb_uart_checks.svh"

    uart_tx_periph #(
        .BIT_PERIOD (BIT_PERIOD),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uart_tx_periph_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ahb_req   (ahb_req),
        .ahb_rsp   (ahb_rsp),
        .irq_clear (irq_clear),
        .tx        (tx),
        .irq_uart  (irq_uart)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic test_t make_test(op_e kind, logic [31:0] addr, logic [31:0] data,
                                        int count, int accept, logic exp_ready,
                                        hresp_e exp_resp, logic exp_irq);
        test_t t;
        t.kind      = kind;
        t.addr      = addr;
        t.data      = data;
        t.count     = 4'(count);
        t.accept    = 4'(accept);
        t.exp_ready = exp_ready;
        t.exp_resp  = exp_resp;
        t.exp_irq   = exp_irq;
        return t;
    endfunction

    function automatic ahb_req_t idle_req();
        ahb_req_t r;
        r = '0;
        r.trans = IDLE;
        return r;
    endfunction

    function automatic ahb_req_t make_req(op_e kind, logic [31:0] addr, logic [31:0] data);
        ahb_req_t r;
        r.sel   = (kind != OP_NOSEL);
        r.addr  = addr;
        r.write = (kind != OP_READ);
        r.trans = (kind == OP_IDLE) ? IDLE : NONSEQ;
        r.size  = 3'b010;  // word
        r.wdata = data;
        return r;
    endfunction

    function automatic ahb_rsp_t make_rsp(logic ready, hresp_e resp);
        ahb_rsp_t r;
        r.rdata = '0;
        r.ready = ready;
        r.resp  = resp;
        return r;
    endfunction

    // entries run in order and the irq flag carries from one to the next
    function automatic void load_tests();
        tests.push_back(make_test(OP_WRITE, TXDATA_ADDR, 32'ha5c3_0f81, 1, 1, 1'b1, OKAY, 1'b0));
        tests.push_back(make_test(OP_READ, TXDATA_ADDR, 32'h0, 1, 0, 1'b0, ERROR, 1'b1));
        tests.push_back(make_test(OP_WRITE, OTHER_ADDR, 32'h1234_5678, 1, 0, 1'b1, OKAY, 1'b1));
        tests.push_back(make_test(OP_NOSEL, TXDATA_ADDR, 32'hdead_beef, 1, 0, 1'b1, OKAY, 1'b1));
        tests.push_back(make_test(OP_CLEAR, TXDATA_ADDR, 32'h0, 0, 0, 1'b1, OKAY, 1'b0));
        tests.push_back(make_test(OP_BURST, TXDATA_ADDR, 32'h3c00_0001, 6, FIFO_DEPTH + 1,
                                  1'b1, OKAY, 1'b0));
        tests.push_back(make_test(OP_IDLE, TXDATA_ADDR, 32'h5555_aaaa, 1, 0, 1'b1, OKAY, 1'b0));
        tests.push_back(make_test(OP_WRITE, TXDATA_ADDR, 32'h8000_ff01, 1, 1, 1'b1, OKAY, 1'b0));
        tests.push_back(make_test(OP_RANDOM, TXDATA_ADDR, 32'h0, 8, 8, 1'b1, OKAY, 1'b0));
    endfunction

    // address phase i overlaps data phase i-1
    task automatic run_bus();
        ahb_req_t r;
        rsp_q.delete();
        for (int i = 0; i <= req_q.size(); i++) begin
            @(posedge clk);
            r = (i < req_q.size()) ? req_q[i] : idle_req();
            r.wdata = (i > 0) ? req_q[i-1].wdata : '0;
            ahb_req <= r;
            if (i > 0) begin
                @(negedge clk);
                rsp_q.push_back(ahb_rsp);  // response to address phase i-1
            end
        end
    endtask

    task automatic wait_bytes(input int n, input int limit, output bit ok);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        ok = (rx_q.size() >= n);
        if (!ok) begin
            err_cnt++;
            $display("timeout: %0d of %0d bytes arrived in %0d cycles", rx_q.size(), n, limit);
        end
    endtask

    task automatic wait_line_idle(input int limit);
        int cyc;
        int high_run;
        cyc = 0;
        high_run = 0;
        while (high_run < 2 * BIT_PERIOD && cyc < limit) begin
            @(negedge clk);
            high_run = (tx === 1'b1) ? high_run + 1 : 0;
            cyc++;
        end
        if (high_run < 2 * BIT_PERIOD) begin
            err_cnt++;
            $display("timeout: tx line did not return to idle within %0d cycles", limit);
        end
    endtask

    // every word of exp_q low byte first and nothing more
    task automatic expect_words();
        int         nb;
        bit         ok;
        logic [7:0] got;
        nb = 4 * exp_q.size();
        wait_bytes(nb, nb * FRAME_CLKS + 4 * FRAME_CLKS, ok);
        if (ok) begin
            foreach (exp_q[j]) begin
                for (int k = 0; k < 4; k++) begin
                    got = rx_q.pop_front();
                    check_byte($sformatf("tx byte %0d of word %0d", k, j), got,
                               8'(exp_q[j] >> (8 * k)));
                end
            end
        end
        wait_line_idle(4 * FRAME_CLKS);
        if (rx_q.size() != 0) begin
            err_cnt++;
            $display("received %0d bytes more than were written", rx_q.size());
            rx_q.delete();
        end
        exp_q.delete();
    endtask

    task automatic expect_quiet();
        int high_cnt;
        high_cnt = 0;
        for (int c = 0; c < QUIET_CLKS; c++) begin
            @(negedge clk);
            if (tx === 1'b1) high_cnt++;
        end
        if (high_cnt != QUIET_CLKS) begin
            err_cnt++;
            $display("tx left the idle level although no word was accepted");
        end
        if (rx_q.size() != 0) begin
            err_cnt++;
            $display("a frame arrived although no word was accepted");
            rx_q.delete();
        end
    endtask

    task automatic single_access(input test_t t, input logic [31:0] data);
        op_e kind;
        kind = (t.kind == OP_RANDOM) ? OP_WRITE : t.kind;
        req_q.delete();
        req_q.push_back(make_req(kind, t.addr, data));
        run_bus();
        check_rsp("ahb_rsp", rsp_q[0], make_rsp(t.exp_ready, t.exp_resp));
        if (kind == OP_WRITE && t.addr == TXDATA_ADDR) begin
            exp_q.delete();
            exp_q.push_back(data);
            expect_words();
        end else begin
            expect_quiet();
        end
    endtask

    task automatic run_burst(input test_t t);
        logic [31:0] w;
        req_q.delete();
        exp_q.delete();
        for (int i = 0; i < int'(t.count); i++) begin
            w = t.data + 32'(i) * 32'h0101_0101;
            req_q.push_back(make_req(OP_WRITE, t.addr, w));
            if (i < int'(t.accept)) exp_q.push_back(w);
        end
        run_bus();
        foreach (rsp_q[i]) begin
            check_rsp($sformatf("ahb_rsp[%0d]", i), rsp_q[i],
                      make_rsp(1'b1, (i < int'(t.accept)) ? OKAY : ERROR));
        end
        expect_words();
    endtask

    task automatic pulse_irq_clear();
        @(posedge clk);
        irq_clear <= 1'b1;
        @(posedge clk);
        irq_clear <= 1'b0;
        @(negedge clk);
    endtask

    // rebuilds frames seen on tx into rx_q
    initial begin
        logic [7:0] data;
        logic       start_b;
        logic       check_b;
        logic       stop_b;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                capture_frame(data, start_b, check_b, stop_b);
                check_byte("tx start bit", {7'd0, start_b}, 8'h00);
                check_byte("tx check bit", {7'd0, check_b}, {7'd0, ^data});  // even parity
                check_byte("tx stop bit", {7'd0, stop_b}, 8'h01);
                rx_q.push_back(data);
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        test_t       t;
        int          errs_before;
        logic [31:0] w;
        lfsr_state = 32'hfbe9_f8ce;
        err_cnt    = 0;
        n_checks   = 0;
        rst_n      = 1'b0;
        irq_clear  = 1'b0;
        ahb_req    = idle_req();
        load_tests();

        // reset values while rst_n is still low
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_rsp("ahb_rsp in reset", ahb_rsp, make_rsp(1'b0, ERROR));
        check_irq(irq_uart, 1'b0);
        check_byte("tx in reset", {7'd0, tx}, 8'h01);
        @(posedge clk);
        rst_n <= 1'b1;

        foreach (tests[i]) begin
            t = tests[i];
            errs_before = err_cnt;
            case (t.kind)
                OP_CLEAR: pulse_irq_clear();
                OP_BURST: run_burst(t);
                OP_RANDOM: begin
                    for (int n = 0; n < int'(t.count); n++) begin
                        draw_word(w);
                        single_access(t, w);
                    end
                end
                default: single_access(t, t.data);
            endcase
            @(negedge clk);
            check_irq(irq_uart, t.exp_irq);
            if (err_cnt == errs_before) begin
                $display("test %0d %s: ok", i, t.kind.name());
            end else begin
                $display("test %0d %s: %0d errors", i, t.kind.name(), err_cnt - errs_before);
            end
        end

        $display("tests %0d, checks %0d, errors %0d", tests.size(), n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: design/uart_tx_periph.sv
`timescale 1ns/1ps

module uart_tx_periph #(
    parameter int BIT_PERIOD = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  uart_tx_pkg::ahb_req_t   ahb_req,
    output uart_tx_pkg::ahb_rsp_t   ahb_rsp,
    input  logic                    irq_clear,
    output logic                    tx,
    output logic                    irq_uart
);

    import uart_tx_pkg::*;

    logic                          push;
    logic [WORD_WIDTH-1:0]         push_data;
    logic [$clog2(FIFO_DEPTH):0]   fifo_used;
    logic                          pop;
    logic                          empty;
    logic [WORD_WIDTH-1:0]         head_data;

    // bus side, producer
    ahb_tx_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) ahb_tx_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ahb_req   (ahb_req),
        .ahb_rsp   (ahb_rsp),
        .irq_clear (irq_clear),
        .fifo_used (fifo_used),
        .push      (push),
        .push_data (push_data),
        .irq_uart  (irq_uart)
    );

    tx_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_word_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .empty     (empty),
        .head_data (head_data),
        .fifo_used (fifo_used)
    );

    // line side, consumer
    uart_word_serializer #(
        .BIT_PERIOD (BIT_PERIOD)
    ) uart_word_serializer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .head_data (head_data),
        .pop       (pop),
        .tx        (tx)
    );

endmodule

// File: design/uart_word_serializer.sv
`timescale 1ns/1ps

module uart_word_serializer #(
    parameter int BIT_PERIOD = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  empty,
    input  logic [uart_tx_pkg::WORD_WIDTH-1:0]    head_data,
    output logic                                  pop,
    output logic                                  tx
);

    import uart_tx_pkg::*;

    localparam int PER_W = (BIT_PERIOD > 1) ? $clog2(BIT_PERIOD) : 1;

    ser_state_e            state;
    logic [PER_W-1:0]      per_cnt;   // clocks within current bit
    logic [3:0]            bit_idx;   // 0..10 within frame
    logic [1:0]            byte_idx;  // 0..3 within word
    logic [WORD_WIDTH-1:0] word_q;
    logic [FRAME_BITS-1:0] frame_q;

    logic                  bit_end;
    logic                  frame_end;
    logic                  word_end;
    logic [3:0]            next_bit;
    logic [1:0]            next_byte;
    logic [BYTE_WIDTH-1:0] next_data;

    // {stop, check, data, start}, sent from bit 0 up
    function automatic logic [FRAME_BITS-1:0] build_frame(input logic [BYTE_WIDTH-1:0] data);
        logic check;
        check = ^data;  // even parity
        return {1'b1, check, data, 1'b0};
    endfunction

    assign pop = (state == SER_IDLE) && !empty;

    assign bit_end   = (state == SER_FRAME) && (per_cnt == PER_W'(BIT_PERIOD - 1));
    assign frame_end = bit_end && (bit_idx == 4'(FRAME_BITS - 1));
    assign word_end  = frame_end && (byte_idx == 2'(BYTES_PER_WORD - 1));

    assign next_bit  = bit_idx + 4'd1;
    assign next_byte = byte_idx + 2'd1;
    assign next_data = word_q[{next_byte, 3'b000} +: BYTE_WIDTH];

    // word and frame payload
    always_ff @(posedge clk) begin
        if (pop) begin
            word_q  <= head_data;
            frame_q <= build_frame(head_data[BYTE_WIDTH-1:0]);  // low byte first
        end else if (frame_end && !word_end) begin
            frame_q <= build_frame(next_data);
        end
    end

    // control FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SER_IDLE;
        end else begin
            case (state)
                SER_IDLE: begin
                    if (pop) begin
                        state <= SER_FRAME;
                    end
                end
                SER_FRAME: begin
                    if (word_end) begin
                        state <= SER_GAP;
                    end
                end
                SER_GAP: begin
                    state <= SER_IDLE;  // one cycle only
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

    // bit timing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            per_cnt <= '0;
        end else if (pop || bit_end) begin
            per_cnt <= '0;
        end else if (state == SER_FRAME) begin
            per_cnt <= per_cnt + 1'b1;
        end
    end

    // bit and byte position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (pop) begin
            bit_idx  <= '0;
            byte_idx <= '0;
        end else if (frame_end) begin
            bit_idx  <= '0;
            byte_idx <= next_byte;  // wraps to 0 after byte 3
        end else if (bit_end) begin
            bit_idx <= next_bit;
        end
    end

    // line driver, idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx <= 1'b1;
        end else if (pop) begin
            tx <= 1'b0;  // start bit of byte 0
        end else if (word_end) begin
            tx <= 1'b1;
        end else if (frame_end) begin
            tx <= 1'b0;  // next frame follows directly
        end else if (bit_end) begin
            tx <= frame_q[next_bit];
        end
    end

endmodule

// File: design/tx_word_fifo.sv
`timescale 1ns/1ps

module tx_word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  push,
    input  logic [uart_tx_pkg::WORD_WIDTH-1:0]    push_data,
    input  logic                                  pop,
    output logic                                  empty,
    output logic [uart_tx_pkg::WORD_WIDTH-1:0]    head_data,
    output logic [$clog2(FIFO_DEPTH):0]           fifo_used
);

    import uart_tx_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];  // show-ahead
    assign fifo_used = count;

endmodule

// File: design/ahb_tx_regs.sv
`timescale 1ns/1ps

module ahb_tx_regs #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  uart_tx_pkg::ahb_req_t                 ahb_req,
    output uart_tx_pkg::ahb_rsp_t                 ahb_rsp,
    input  logic                                  irq_clear,
    input  logic [$clog2(FIFO_DEPTH):0]           fifo_used,
    output logic                                  push,
    output logic [uart_tx_pkg::WORD_WIDTH-1:0]    push_data,
    output logic                                  irq_uart
);

    import uart_tx_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic             addr_phase;
    logic             hit;
    logic             wr_evt;
    logic             rd_evt;
    logic [CNT_W:0]   used_total;
    logic             has_space;
    logic             wr_accept;

    // only NONSEQ opens a transfer, no bursts here
    assign addr_phase = ahb_req.sel && (ahb_req.trans == NONSEQ);
    assign hit        = (ahb_req.addr == TXDATA_ADDR);
    assign wr_evt     = addr_phase && hit && ahb_req.write;
    assign rd_evt     = addr_phase && hit && !ahb_req.write;

    // a push still in its data phase counts as already stored
    assign used_total = {1'b0, fifo_used} + (CNT_W + 1)'(push);
    assign has_space  = (used_total < (CNT_W + 1)'(FIFO_DEPTH));
    assign wr_accept  = wr_evt && has_space;

    // write data arrives one cycle after the address phase
    assign push_data = ahb_req.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= wr_accept;  // lands in the data phase
        end
    end

    // registered response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ahb_rsp.rdata <= '0;
            ahb_rsp.ready <= 1'b0;
            ahb_rsp.resp  <= ERROR;
        end else begin
            ahb_rsp.rdata <= '0;  // nothing readable
            if (rd_evt) begin
                ahb_rsp.ready <= 1'b0;  // write-only register
                ahb_rsp.resp  <= ERROR;
            end else if (wr_evt && !has_space) begin
                ahb_rsp.ready <= 1'b1;  // full, word dropped
                ahb_rsp.resp  <= ERROR;
            end else begin
                ahb_rsp.ready <= 1'b1;
                ahb_rsp.resp  <= OKAY;
            end
        end
    end

    // sticky flag for illegal reads, clear has priority
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_uart <= 1'b0;
        end else if (irq_clear) begin
            irq_uart <= 1'b0;
        end else if (rd_evt) begin
            irq_uart <= 1'b1;
        end
    end

endmodule

// File: design/uart_tx_pkg.sv
package uart_tx_pkg;

    // bus widths and register map
    localparam int WORD_WIDTH = 32;
    localparam logic [WORD_WIDTH-1:0] TXDATA_ADDR = 32'h4000_0010;  // write-only data reg

    // uart framing
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;
    localparam int FRAME_BITS     = 11;  // start + 8 data + check + stop

    // ahb transfer types
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

    // master to slave, 71 bits
    typedef struct packed {
        logic                  sel;
        logic [WORD_WIDTH-1:0] addr;
        logic                  write;
        htrans_e               trans;
        logic [2:0]            size;
        logic [WORD_WIDTH-1:0] wdata;
    } ahb_req_t;

    // slave to master, 35 bits
    typedef struct packed {
        logic [WORD_WIDTH-1:0] rdata;
        logic                  ready;
        hresp_e                resp;
    } ahb_rsp_t;

    typedef enum logic [1:0] {
        SER_IDLE  = 2'b00,
        SER_FRAME = 2'b01,
        SER_GAP   = 2'b10
    } ser_state_e;

endpackage
